// File: hw/riscv_types.sv
// RV32I pipeline slice types
`default_nettype none

package riscv_types;

  // Major opcodes kept by the slice
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP_REG = 7'b0110011,
    OP_LUI = 7'b0110111
  } op_t;

  // ALU operations, encoded as {fun7_5, fun3}
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SLL  = 4'b0001,
    SLT  = 4'b0010,
    SLTU = 4'b0011,
    XOR  = 4'b0100,
    SRL  = 4'b0101,
    OR   = 4'b0110,
    AND  = 4'b0111,
    SUB  = 4'b1000,
    SRA  = 4'b1101
  } alu_t;

  // Capture to decode
  typedef struct packed {
    logic        valid;
    logic [31:0] inst;
  } if_id_reg_t;

  // Decode to execute
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] imm;
    alu_t        alu_op;
    logic        alu_src;
    logic        lui;
    logic        reg_write;
    logic        illegal;
  } id_exe_reg_t;

  // Execute to writeback
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] result;
    logic        reg_write;
    logic        illegal;
  } exe_wb_reg_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] result;
    logic        illegal;
  } retire_t;

endpackage

`default_nettype wire

// File: hw/inst_capture.sv
// Instruction capture receiver
`timescale 1ns/1ps
`default_nettype none

module inst_capture import riscv_types::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        inst_req,
  input  logic [31:0] inst,
  output logic        inst_ack,
  output if_id_reg_t  if_id
);

  typedef enum logic {
    IDLE,
    ACKED
  } state_t;

  state_t state;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= IDLE;
      if_id <= '0;
    end else begin
      // Valid is a single-cycle strobe
      if_id.valid <= 1'b0;
      case (state)
        IDLE: begin
          if (inst_req) begin
            state    <= ACKED;
            if_id.valid <= 1'b1;
            if_id.inst  <= inst;
          end
        end
        ACKED: begin
          if (!inst_req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign inst_ack = (state == ACKED);

  // Ack holds as long as the sender keeps req up
  ack_held_while_req: assert property (
    @(posedge clk) disable iff (!reset_n)
    (inst_ack && inst_req) |=> inst_ack
  );

endmodule

`default_nettype wire

// File: hw/reg_file.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic        clk,
  input  logic        reset_n,
  input  logic [4:0]  rd_addr1,
  input  logic [4:0]  rd_addr2,
  output logic [31:0] rd_data1,
  output logic [31:0] rd_data2,
  input  logic        wr_en,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data
);

  // x0 has no storage
  logic [31:0] regs [31:1];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != 5'd0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Write-through on address match
  assign rd_data1 = (rd_addr1 == 5'd0) ? 32'd0 :
                    (wr_en && (wr_addr == rd_addr1)) ? wr_data : regs[rd_addr1];
  assign rd_data2 = (rd_addr2 == 5'd0) ? 32'd0 :
                    (wr_en && (wr_addr == rd_addr2)) ? wr_data : regs[rd_addr2];

  no_x0_write: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(wr_en && (wr_addr == 5'd0))
  );

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module decode_stage import riscv_types::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  if_id_reg_t  if_id,
  output logic [4:0]  rd_addr1,
  output logic [4:0]  rd_addr2,
  input  logic [31:0] rd_data1,
  input  logic [31:0] rd_data2,
  output id_exe_reg_t id_exe
);

  op_t         opcode;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  fun3;
  logic [6:0]  fun7;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  alu_t        alu_op;
  logic        legal;
  id_exe_reg_t id_exe_d;

  assign opcode = op_t'(if_id.inst[6:0]);
  assign rd     = if_id.inst[11:7];
  assign fun3   = if_id.inst[14:12];
  assign rs1    = if_id.inst[19:15];
  assign rs2    = if_id.inst[24:20];
  assign fun7   = if_id.inst[31:25];

  assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
  assign imm_u = {if_id.inst[31:12], 12'd0};

  assign rd_addr1 = rs1;
  assign rd_addr2 = rs2;

  always_comb begin
    alu_op = ADD;
    legal  = 1'b1;
    case (opcode)
      OP_REG: begin
        if (fun7 == 7'b0000000) begin
          alu_op = alu_t'({1'b0, fun3});
        end else if ((fun7 == 7'b0100000) && ((fun3 == 3'b000) || (fun3 == 3'b101))) begin
          alu_op = alu_t'({1'b1, fun3});
        end else begin
          legal = 1'b0;
        end
      end
      OP_IMM: begin
        if (fun3 == 3'b001) begin
          legal  = (fun7 == 7'b0000000);
          alu_op = SLL;
        end else if (fun3 == 3'b101) begin
          // fun7_5 picks arithmetic shift
          legal  = (fun7 == 7'b0000000) || (fun7 == 7'b0100000);
          alu_op = fun7[5] ? SRA : SRL;
        end else begin
          // ADDI and friends never turn into SUB
          alu_op = alu_t'({1'b0, fun3});
        end
      end
      OP_LUI: alu_op = ADD;
      default: legal = 1'b0;
    endcase
    // Keep illegal ops on a defined encoding
    if (!legal) begin
      alu_op = ADD;
    end
  end

  always_comb begin
    id_exe_d.valid     = if_id.valid;
    id_exe_d.rd        = rd;
    id_exe_d.rs1       = rs1;
    id_exe_d.rs2       = rs2;
    id_exe_d.rdata1    = rd_data1;
    id_exe_d.rdata2    = rd_data2;
    id_exe_d.imm       = (opcode == OP_LUI) ? imm_u : imm_i;
    id_exe_d.alu_op    = alu_op;
    id_exe_d.alu_src   = (opcode == OP_IMM) || (opcode == OP_LUI);
    id_exe_d.lui       = (opcode == OP_LUI);
    id_exe_d.reg_write = legal;
    id_exe_d.illegal   = !legal;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      id_exe <= '0;
    end else begin
      id_exe <= id_exe_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
// Execute stage with forwarding
`timescale 1ns/1ps
`default_nettype none

module execute_stage import riscv_types::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  id_exe_reg_t id_exe,
  output exe_wb_reg_t exe_wb
);

  logic        fwd_ok;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] rs2_val;
  logic [31:0] alu_out;

  // Forward from the instruction now in writeback
  assign fwd_ok  = exe_wb.valid && exe_wb.reg_write && (exe_wb.rd != 5'd0);
  assign op_a    = (fwd_ok && (exe_wb.rd == id_exe.rs1)) ? exe_wb.result : id_exe.rdata1;
  assign rs2_val = (fwd_ok && (exe_wb.rd == id_exe.rs2)) ? exe_wb.result : id_exe.rdata2;
  assign op_b    = id_exe.alu_src ? id_exe.imm : rs2_val;

  always_comb begin
    case (id_exe.alu_op)
      ADD:     alu_out = op_a + op_b;
      SUB:     alu_out = op_a - op_b;
      SLL:     alu_out = op_a << op_b[4:0];
      SLT:     alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      SLTU:    alu_out = {31'd0, op_a < op_b};
      XOR:     alu_out = op_a ^ op_b;
      SRL:     alu_out = op_a >> op_b[4:0];
      SRA:     alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
      OR:      alu_out = op_a | op_b;
      AND:     alu_out = op_a & op_b;
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      exe_wb <= '0;
    end else begin
      exe_wb.valid     <= id_exe.valid;
      exe_wb.rd        <= id_exe.rd;
      exe_wb.result    <= id_exe.lui ? id_exe.imm : alu_out;
      exe_wb.reg_write <= id_exe.reg_write;
      exe_wb.illegal   <= id_exe.illegal;
    end
  end

  // Decode must only hand over known operations
  alu_op_defined: assert property (
    @(posedge clk) disable iff (!reset_n)
    id_exe.valid |-> (id_exe.alu_op inside {ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND, SUB, SRA})
  );

endmodule

`default_nettype wire

// File: hw/writeback_stage.sv
// Writeback and retire
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import riscv_types::*; (
  input  exe_wb_reg_t exe_wb,
  output logic        wr_en,
  output logic [4:0]  wr_addr,
  output logic [31:0] wr_data,
  output logic        retire_valid,
  output retire_t     retire
);

  // Only legal writes to a real register
  assign wr_en = exe_wb.valid && exe_wb.reg_write && !exe_wb.illegal && (exe_wb.rd != 5'd0);
  assign wr_addr = exe_wb.rd;
  assign wr_data = exe_wb.result;

  assign retire_valid   = exe_wb.valid;
  assign retire.rd      = exe_wb.rd;
  assign retire.result  = exe_wb.illegal ? 32'd0 : exe_wb.result;
  assign retire.illegal = exe_wb.illegal;

endmodule

`default_nettype wire

// File: hw/alu_pipe_top.sv
// RV32I ALU pipeline top
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_top import riscv_types::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        inst_req,
  input  logic [31:0] inst,
  output logic        inst_ack,
  output logic        retire_valid,
  output retire_t     retire
);

  if_id_reg_t  if_id;
  id_exe_reg_t id_exe;
  exe_wb_reg_t exe_wb;
  logic [4:0]  rd_addr1;
  logic [4:0]  rd_addr2;
  logic [31:0] rd_data1;
  logic [31:0] rd_data2;
  logic        wr_en;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;

  inst_capture u_capture (
    .clk      (clk),
    .reset_n  (reset_n),
    .inst_req (inst_req),
    .inst     (inst),
    .inst_ack (inst_ack),
    .if_id    (if_id)
  );

  decode_stage u_decode (
    .clk      (clk),
    .reset_n  (reset_n),
    .if_id    (if_id),
    .rd_addr1 (rd_addr1),
    .rd_addr2 (rd_addr2),
    .rd_data1 (rd_data1),
    .rd_data2 (rd_data2),
    .id_exe   (id_exe)
  );

  reg_file u_regs (
    .clk      (clk),
    .reset_n  (reset_n),
    .rd_addr1 (rd_addr1),
    .rd_addr2 (rd_addr2),
    .rd_data1 (rd_data1),
    .rd_data2 (rd_data2),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  execute_stage u_execute (
    .clk     (clk),
    .reset_n (reset_n),
    .id_exe  (id_exe),
    .exe_wb  (exe_wb)
  );

  writeback_stage u_writeback (
    .exe_wb       (exe_wb),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

`default_nettype wire

// File: verif/alu_pipe_tb.sv
// ALU pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_tb import riscv_types::*; ();

  localparam int WAIT_LIMIT = 20;

  logic        clk;
  logic        reset_n;
  logic        inst_req;
  logic [31:0] inst;
  logic        inst_ack;
  logic        retire_valid;
  retire_t     retire;

  logic [31:0] lfsr_state;
  logic [31:0] shadow [32];
  retire_t     exp_q [$];
  retire_t     exp_head;
  int          exp_count;
  int          err_count;
  int          tests_passed;
  int          tests_failed;
  logic        timed_out;

  alu_pipe_top UUT (
    .clk          (clk),
    .reset_n      (reset_n),
    .inst_req     (inst_req),
    .inst         (inst),
    .inst_ack     (inst_ack),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  // alt picks SUB or SRA
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return (a >> b[4:0]) | ({32{alt & a[31]}} & ~(32'hffffffff >> b[4:0]));
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Expected retire bundle, shadow registers updated in program order
  function automatic retire_t predict(input logic [31:0] w);
    retire_t     r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ok;
    f3  = w[14:12];
    f7  = w[31:25];
    a   = shadow[w[19:15]];
    b   = shadow[w[24:20]];
    imm = {{20{w[31]}}, w[31:20]};
    ok  = 1'b1;
    r.rd = w[11:7];
    r.result = '0;
    case (w[6:0])
      7'b0110011: begin
        ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        r.result = ref_alu(f3, f7[5], a, b);
      end
      7'b0010011: begin
        if (f3 == 3'd1) ok = (f7 == 7'h00);
        if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
        r.result = ref_alu(f3, (f3 == 3'd5) && f7[5], a, imm);
      end
      7'b0110111: r.result = {w[31:12], 12'h000};
      default: ok = 1'b0;
    endcase
    r.illegal = !ok;
    if (!ok) r.result = '0;
    else if (r.rd != 5'd0) shadow[r.rd] = r.result;
    return r;
  endfunction

  function automatic void refresh_head();
    exp_count = exp_q.size();
    if (exp_count > 0) exp_head = exp_q[0];
  endfunction

  always @(posedge clk) begin
    if (reset_n && retire_valid && (exp_q.size() > 0)) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  chk_ack_rise: assert property (@(posedge clk) disable iff (!reset_n)
    (inst_req && !inst_ack) |=> inst_ack)
    else begin
      err_count++;
      $display("At %0t inst_ack did not rise one cycle after the request", $time);
    end

  chk_ack_fall: assert property (@(posedge clk) disable iff (!reset_n)
    $fell(inst_ack) |-> !$past(inst_req))
    else begin
      err_count++;
      $display("At %0t inst_ack dropped while inst_req was still high", $time);
    end

  chk_latency: assert property (@(posedge clk) disable iff (!reset_n)
    (inst_req && !inst_ack) |-> ##3 retire_valid ##1 !retire_valid)
    else begin
      err_count++;
      $display("At %0t retire_valid did not pulse once, three cycles after accept", $time);
    end

  chk_retire: assert property (@(posedge clk) disable iff (!reset_n)
    retire_valid |-> ((exp_count > 0) && (retire == exp_head)))
    else begin
      err_count++;
      $display("Mismatch at %0t: retire rd=%0d result=%h illegal=%b, expected %0d/%h/%b",
               $time, $sampled(retire.rd), $sampled(retire.result),
               $sampled(retire.illegal), $sampled(exp_head.rd),
               $sampled(exp_head.result), $sampled(exp_head.illegal));
    end

  task automatic finish_run();
    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, err_count);
    if ((err_count == 0) && !timed_out) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    $display("Timeout at %0t: %s", $time, what);
    finish_run();
  endtask

  // Called on a falling edge with inst_ack low
  task automatic send_inst(input logic [31:0] word);
    int n;
    int hold;
    exp_q.push_back(predict(word));
    refresh_head();
    inst = word;
    inst_req = 1'b1;
    n = 0;
    while (!inst_ack) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) report_timeout("inst_ack never rose");
    end
    // Sender may keep req up for a few cycles after ack
    hold = int'(rand_bits(2));
    repeat (hold) @(negedge clk);
    inst_req = 1'b0;
    n = 0;
    while (inst_ack) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) report_timeout("inst_ack never fell");
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    int n;
    n = 0;
    while (exp_q.size() > 0) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) report_timeout("expected retires never arrived");
    end
    @(negedge clk);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  initial begin
    int         base;
    logic [11:0] imm;
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] src;
    lfsr_state = 32'd71823;
    reset_n = 1'b0;
    inst_req = 1'b0;
    inst = '0;
    err_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
    refresh_head();
    repeat (2) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);

    base = err_count;
    assert (!inst_ack && !retire_valid)
      else begin
        err_count++;
        $display("Mismatch at %0t: inst_ack=%b retire_valid=%b after reset, expected 0/0",
                 $time, inst_ack, retire_valid);
      end
    end_test("reset", base);

    // x1..x4 via ADDI from x0, x5 negative via LUI
    base = err_count;
    for (int r = 1; r <= 4; r++) begin
      send_inst(i_type(12'(rand_bits(12)), 5'd0, 3'b000, 5'(r)));
    end
    send_inst({1'b1, 19'(rand_bits(19)), 5'd5, 7'b0110111});
    for (int f = 0; f < 8; f++) begin
      imm = 12'(rand_bits(12));
      if ((f == 1) || (f == 5)) imm[11:5] = 7'h00;
      send_inst(i_type(imm, 5'd5, 3'(f), 5'(6 + f)));
      send_inst(i_type(imm, 5'(1 + f % 4), 3'(f), 5'(14 + f)));
    end
    send_inst(i_type({7'h20, 5'(rand_bits(5))}, 5'd5, 3'b101, 5'd22));
    send_inst(i_type(12'h7ff, 5'd5, 3'b010, 5'd23));
    send_inst(i_type(12'hfff, 5'd5, 3'b011, 5'd24));
    send_inst(i_type(12'h800, 5'd1, 3'b010, 5'd25));
    end_test("immediate", base);

    base = err_count;
    for (int r = 10; r < 14; r++) begin
      send_inst({20'(rand_bits(20)), 5'(r), 7'b0110111});
      send_inst(i_type(12'(rand_bits(12)), 5'(r), 3'b000, 5'(r)));
    end
    // Dependent chain, SUB and SRA last
    src = 5'd10;
    for (int k = 0; k < 10; k++) begin
      f7 = (k >= 8) ? 7'h20 : 7'h00;
      f3 = (k == 8) ? 3'b000 : ((k == 9) ? 3'b101 : 3'(k));
      send_inst(r_type(f7, 5'(10 + rand_bits(2)), src, f3, 5'(14 + k)));
      src = 5'(14 + k);
    end
    end_test("register", base);

    base = err_count;
    send_inst(i_type(12'(rand_bits(12)), 5'd1, 3'b000, 5'd0));
    send_inst(r_type(7'h00, 5'd2, 5'd0, 3'b000, 5'd26));
    send_inst(r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd27));
    end_test("x0", base);

    base = err_count;
    send_inst(i_type(12'h123, 5'd0, 3'b000, 5'd28));
    send_inst({17'(rand_bits(17)), 3'b010, 5'd28, 7'b0000011});
    send_inst(i_type({7'h20, 5'd3}, 5'd28, 3'b001, 5'd28));
    send_inst(r_type(7'h01, 5'd1, 5'd28, 3'b000, 5'd28));
    send_inst(r_type(7'h00, 5'd0, 5'd28, 3'b000, 5'd29));
    end_test("illegal", base);

    finish_run();
  end

endmodule

`default_nettype wire

// File: compile.f
hw/riscv_types.sv
hw/inst_capture.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/alu_pipe_top.sv
verif/alu_pipe_tb.sv

// File: Makefile
SHELL     := /bin/bash
VERILATOR ?= verilator
TOP       ?= alu_pipe_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
